// ==== src/rotPkg.sv ====
`default_nettype none

package rotPkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int SampleWidth = 18;
   localparam int FracBits    = 16;
   localparam int PhaseWidth  = 5;

   // output fifo depth, also the initial upstream credit grant
   localparam int QueueDepth  = 8;
   localparam int PtrWidth    = $clog2(QueueDepth);
   localparam int CountWidth  = $clog2(QueueDepth) + 1;
   // downstream credits may pile up beyond the fifo depth
   localparam int CreditWidth = 8;

   // ------------------------------------------------------------------------
   // Q1.16 coefficients, 0 to 4 steps of 11.25 degrees
   // ------------------------------------------------------------------------
   localparam logic signed [SampleWidth-1:0] cosTable [0:4] = '{
      18'sd65536, 18'sd64277, 18'sd60547, 18'sd54491, 18'sd46341
   };
   localparam logic signed [SampleWidth-1:0] sinTable [0:4] = '{
      18'sd0, 18'sd12785, 18'sd25080, 18'sd36410, 18'sd46341
   };

   // phase index split for the folding logic
   typedef struct packed {
      logic [1:0] quadrant;
      logic       mirror;
      logic [1:0] step;
   } phaseFieldsT;

   // one index word, used as a number or as fold fields
   typedef union packed {
      logic [PhaseWidth-1:0] raw;
      phaseFieldsT           fields;
   } phaseIndexT;

   typedef struct packed {
      logic signed [SampleWidth-1:0] i;
      logic signed [SampleWidth-1:0] q;
   } iqSampleT;

   // input word from upstream
   typedef struct packed {
      iqSampleT              iq;
      logic [PhaseWidth-1:0] phaseStep;
      logic                  sync;
   } inSampleT;

   // pipeline and output word
   typedef struct packed {
      iqSampleT   iq;
      phaseIndexT phase;
   } rotSampleT;

endpackage

`default_nettype wire

// ==== src/phaseAccum.sv ====
`default_nettype none

module phaseAccum (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    inValid,
   input  wire rotPkg::inSampleT  inSample,
   output logic                   accValid,
   output rotPkg::rotSampleT      accSample
);

   import rotPkg::*;

   // stored phase, modulo 32
   phaseIndexT phase;
   phaseIndexT newPhase;

   // sync reloads the phase, otherwise step forward
   always_comb begin
      if (inSample.sync) begin
         newPhase.raw = inSample.phaseStep;
      end else begin
         // wraps naturally at 5 bits
         newPhase.raw = phase.raw + inSample.phaseStep;
      end
   end

   // phase state and valid
   always_ff @(posedge clk) begin
      if (reset) begin
         phase.raw <= '0;
         accValid  <= 1'b0;
      end else begin
         accValid <= inValid;
         if (inValid) begin
            phase <= newPhase;
         end
      end
   end

   // sample tagged with its rotation index
   always_ff @(posedge clk) begin
      if (inValid) begin
         accSample.iq    <= inSample.iq;
         accSample.phase <= newPhase;
      end
   end

endmodule

`default_nettype wire

// ==== src/rot.sv ====
`default_nettype none

module rot (
   input  wire                   clk,
   input  wire                   reset,
   input  wire rotPkg::iqSampleT iqIn,
   input  wire [2:0]             angle,
   output rotPkg::iqSampleT      iqRot
);

   import rotPkg::*;

   // table coefficients for the current angle
   logic signed [SampleWidth-1:0] cosCoef;
   logic signed [SampleWidth-1:0] sinCoef;

   // stage 1 products, full precision
   logic signed [2*SampleWidth-1:0] iCos;
   logic signed [2*SampleWidth-1:0] qSin;
   logic signed [2*SampleWidth-1:0] iSin;
   logic signed [2*SampleWidth-1:0] qCos;

   // stage 2 sums, one guard bit
   logic signed [2*SampleWidth:0] sumI;
   logic signed [2*SampleWidth:0] sumQ;

   // ------------------------------------------------------------------------
   // coefficient lookup
   // ------------------------------------------------------------------------
   always_comb begin
      // fold never gives more than 4 steps
      if (angle > 3'd4) begin
         cosCoef = cosTable[4];
         sinCoef = sinTable[4];
      end else begin
         cosCoef = cosTable[angle];
         sinCoef = sinTable[angle];
      end
   end

   // ------------------------------------------------------------------------
   // stage 1, four products
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         iCos <= '0;
         qSin <= '0;
         iSin <= '0;
         qCos <= '0;
      end else begin
         iCos <= iqIn.i * cosCoef;
         qSin <= iqIn.q * sinCoef;
         iSin <= iqIn.i * sinCoef;
         qCos <= iqIn.q * cosCoef;
      end
   end

   // rotation by plus angle
   always_comb begin
      sumI = iCos - qSin;
      sumQ = iSin + qCos;
   end

   // ------------------------------------------------------------------------
   // stage 2, floor to Q1.16 and keep 18 bits
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         iqRot <= '0;
      end else begin
         iqRot.i <= SampleWidth'(sumI >>> FracBits);
         iqRot.q <= SampleWidth'(sumQ >>> FracBits);
      end
   end

endmodule

`default_nettype wire

// ==== src/rotator.sv ====
`default_nettype none

module rotator (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    accValid,
   input  wire rotPkg::rotSampleT accSample,
   output logic                   rotValid,
   output rotPkg::rotSampleT      rotSample
);

   import rotPkg::*;

   iqSampleT   iqLim;
   iqSampleT   foldIq;
   iqSampleT   iqRot;
   logic [2:0] foldAngle;
   logic [2:0] angleNext;
   // valid and phase follow the data through fold and rot
   logic [2:0] validDly;
   phaseIndexT phaseDly [0:2];
   logic       negI;
   logic       negQ;

   // ------------------------------------------------------------------------
   // clamp, keeps negation in range
   // ------------------------------------------------------------------------
   always_comb begin
      iqLim = accSample.iq;
      if (accSample.iq.i == -18'sd131072) begin
         iqLim.i = -18'sd131071;
      end
      if (accSample.iq.q == -18'sd131072) begin
         iqLim.q = -18'sd131071;
      end
   end

   // fine angle, mirrored octants count back from 8
   assign angleNext = accSample.phase.fields.mirror ?
                      3'(4'd8 - 4'(accSample.phase.raw[2:0])) :
                      3'(accSample.phase.fields.step);

   // ------------------------------------------------------------------------
   // fold register, swap and negate by octant
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      foldAngle <= angleNext;
      case ({accSample.phase.fields.quadrant, accSample.phase.fields.mirror})
         3'd0: foldIq <= '{i: iqLim.i, q: iqLim.q};
         3'd1: foldIq <= '{i: iqLim.q, q: iqLim.i};
         // second quadrant
         3'd2: foldIq <= '{i: -iqLim.q, q: iqLim.i};
         3'd3: foldIq <= '{i: -iqLim.i, q: iqLim.q};
         // third quadrant
         3'd4: foldIq <= '{i: -iqLim.i, q: -iqLim.q};
         3'd5: foldIq <= '{i: -iqLim.q, q: -iqLim.i};
         // fourth quadrant
         3'd6: foldIq <= '{i: iqLim.q, q: -iqLim.i};
         default: foldIq <= '{i: iqLim.i, q: -iqLim.q};
      endcase
   end

   rot rot (
      .clk   (clk),
      .reset (reset),
      .iqIn  (foldIq),
      .angle (foldAngle),
      .iqRot (iqRot)
   );

   // three cycle delay, fold plus two rot stages
   always_ff @(posedge clk) begin
      if (reset) begin
         validDly <= '0;
      end else begin
         validDly <= {validDly[1:0], accValid};
      end
   end

   always_ff @(posedge clk) begin
      phaseDly[0] <= accSample.phase;
      phaseDly[1] <= phaseDly[0];
      phaseDly[2] <= phaseDly[1];
   end

   // octants 1 and 5 flip I, octants 3 and 7 flip Q
   assign negI = phaseDly[2].fields.mirror & ~phaseDly[2].fields.quadrant[0];
   assign negQ = phaseDly[2].fields.mirror & phaseDly[2].fields.quadrant[0];

   // ------------------------------------------------------------------------
   // sign fix register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rotValid <= 1'b0;
      end else begin
         rotValid <= validDly[2];
      end
   end

   always_ff @(posedge clk) begin
      rotSample.iq.i  <= negI ? -iqRot.i : iqRot.i;
      rotSample.iq.q  <= negQ ? -iqRot.q : iqRot.q;
      rotSample.phase <= phaseDly[2];
   end

endmodule

`default_nettype wire

// ==== src/creditQueue.sv ====
`default_nettype none

module creditQueue (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    rotValid,
   input  wire rotPkg::rotSampleT rotSample,
   output logic                   inCredit,
   input  wire                    outCredit,
   output logic                   outValid,
   output rotPkg::rotSampleT      outSample
);

   import rotPkg::*;

   // ------------------------------------------------------------------------
   // fifo storage and pointers
   // ------------------------------------------------------------------------
   rotSampleT             mem [0:QueueDepth-1];
   logic [PtrWidth-1:0]   wrPtr;
   logic [PtrWidth-1:0]   rdPtr;
   logic [CountWidth-1:0] count;

   // credits returned by downstream, not yet spent
   logic [CreditWidth-1:0] outCredits;
   // upstream credits still owed
   logic [CountWidth-1:0]  pendingGrants;
   logic                   grant;

   // head leaves when there is data and a credit to spend
   assign outValid  = (count != '0) && (outCredits != '0);
   assign outSample = mem[rdPtr];

   always_ff @(posedge clk) begin
      if (rotValid) begin
         mem[wrPtr] <= rotSample;
      end
   end

   // pointers wrap at the power of two depth
   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (rotValid) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (outValid) begin
            rdPtr <= rdPtr + 1'b1;
         end
         count <= count + CountWidth'(rotValid) - CountWidth'(outValid);
      end
   end

   // ------------------------------------------------------------------------
   // downstream credit counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         outCredits <= '0;
      end else begin
         outCredits <= outCredits + CreditWidth'(outCredit) - CreditWidth'(outValid);
      end
   end

   // ------------------------------------------------------------------------
   // upstream grants
   // ------------------------------------------------------------------------
   // full depth owed after reset, one more per item sent
   assign grant = (pendingGrants != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         pendingGrants <= CountWidth'(QueueDepth);
         inCredit      <= 1'b0;
      end else begin
         // at most one pulse per cycle
         inCredit      <= grant;
         pendingGrants <= pendingGrants + CountWidth'(outValid) - CountWidth'(grant);
      end
   end

endmodule

`default_nettype wire

// ==== src/phaseRotTop.sv ====
`default_nettype none

module phaseRotTop (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   inValid,
   input  wire rotPkg::inSampleT inSample,
   output logic                  inCredit,
   output logic                  outValid,
   output rotPkg::rotSampleT     outSample,
   input  wire                   outCredit
);

   import rotPkg::*;

   // ------------------------------------------------------------------------
   // pipeline wiring
   // ------------------------------------------------------------------------
   // accumulator to rotator
   logic      accValid;
   rotSampleT accSample;

   // rotator to queue
   logic      rotValid;
   rotSampleT rotSample;

   // phase tag, one cycle
   phaseAccum phaseAccum (
      .clk       (clk),
      .reset     (reset),
      .inValid   (inValid),
      .inSample  (inSample),
      .accValid  (accValid),
      .accSample (accSample)
   );

   // fold, fine rotation and sign fix, four cycles
   rotator rotator (
      .clk       (clk),
      .reset     (reset),
      .accValid  (accValid),
      .accSample (accSample),
      .rotValid  (rotValid),
      .rotSample (rotSample)
   );

   // output fifo with credits on both sides
   creditQueue creditQueue (
      .clk       (clk),
      .reset     (reset),
      .rotValid  (rotValid),
      .rotSample (rotSample),
      .inCredit  (inCredit),
      .outCredit (outCredit),
      .outValid  (outValid),
      .outSample (outSample)
   );

endmodule

`default_nettype wire

// ==== tests/phaseRotTop_sva.sv ====
`default_nettype none

module creditQueueSva (
   input wire                          clk,
   input wire                          reset,
   input wire                          rotValid,
   input wire                          outValid,
   input wire                          inCredit,
   input wire                          outCredit,
   input wire [rotPkg::CountWidth-1:0] count
);

   import rotPkg::*;

   // downstream credits seen at the ports, not yet spent
   logic [7:0] creditsHeld;
   // input credits granted and not yet freed by a send
   logic [7:0] grantsOpen;

   always_ff @(posedge clk) begin
      if (reset) begin
         creditsHeld <= '0;
         grantsOpen  <= '0;
      end else begin
         creditsHeld <= creditsHeld + 8'(outCredit) - 8'(outValid);
         grantsOpen  <= grantsOpen + 8'(inCredit) - 8'(outValid);
      end
   end

   noWriteWhenFull: assert property (@(posedge clk) disable iff (reset)
      !(rotValid && count == CountWidth'(QueueDepth)))
      else $error("queue written while full");

   noSendWithoutCredit: assert property (@(posedge clk) disable iff (reset)
      outValid |-> creditsHeld != '0)
      else $error("outValid with zero downstream credits");

   quietAfterReset: assert property (@(posedge clk)
      reset |=> (!outValid && !inCredit))
      else $error("outValid or inCredit high after reset");

   // covers the initial burst and every later regrant
   grantLimit: assert property (@(posedge clk) disable iff (reset)
      grantsOpen <= 8'(QueueDepth))
      else $error("more credit grants than free queue slots");

endmodule

bind creditQueue creditQueueSva creditChecks (
   .clk       (clk),
   .reset     (reset),
   .rotValid  (rotValid),
   .outValid  (outValid),
   .inCredit  (inCredit),
   .outCredit (outCredit),
   .count     (count)
);

`default_nettype wire

// ==== tests/phaseRotTb.sv ====
`default_nettype none

module phaseRotTb;

   import rotPkg::*;

   localparam int MaxLines      = 64;
   localparam int TimeoutCycles = 200;
   // trace sections, end index of each
   localparam int ZeroEnd       = 3;
   localparam int PhasesEnd     = 35;
   localparam int AccumEnd      = 45;
   localparam int NumTests      = 5;

   logic      clk;
   logic      reset;
   logic      inValid;
   inSampleT  inSample;
   logic      inCredit;
   logic      outValid;
   rotSampleT outSample;
   logic      outCredit = 1'b0;

   // stimulus and expected columns
   logic [17:0] stimI [0:MaxLines-1];
   logic [17:0] stimQ [0:MaxLines-1];
   logic [4:0]  stimStep [0:MaxLines-1];
   logic        stimSync [0:MaxLines-1];
   logic [17:0] expI [0:MaxLines-1];
   logic [17:0] expQ [0:MaxLines-1];
   logic [4:0]  expPhase [0:MaxLines-1];

   int          lineCount;
   int          sentCount;
   int          heldCredits;
   int          outCount;
   int          creditsIn;
   int          creditsReturned;
   int          gapLeft;
   int          errors;
   int          testErrors [0:NumTests-1];
   string       testNames [0:NumTests-1];
   logic [31:0] lfsr;
   logic        aborted;
   string       abortReason;

   phaseRotTop DUT (
      .clk       (clk),
      .reset     (reset),
      .inValid   (inValid),
      .inSample  (inSample),
      .inCredit  (inCredit),
      .outValid  (outValid),
      .outSample (outSample),
      .outCredit (outCredit)
   );

   always #4 clk = ~clk;

   // taps 32 22 2 1
   function automatic logic [31:0] nextLfsr(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic int testOf(input int idx);
      if (idx < ZeroEnd) begin
         return 0;
      end else if (idx < PhasesEnd) begin
         return 1;
      end
      return 2;
   endfunction

   task automatic loadTrace;
      int          fd;
      int          rc;
      string       line;
      logic [31:0] v [0:6];
      fd = $fopen("tests/rotTrace.txt", "r");
      if (fd == 0) begin
         aborted = 1'b1;
         abortReason = "could not open the trace file tests/rotTrace.txt";
         return;
      end
      while (!$feof(fd) && lineCount < MaxLines) begin
         rc = $fgets(line, fd);
         // skip comments and blank lines
         if (rc != 0 && line.len() > 0 && line.getc(0) != "#") begin
            rc = $sscanf(line, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
            if (rc == 7) begin
               stimI[lineCount]    = v[0][17:0];
               stimQ[lineCount]    = v[1][17:0];
               stimStep[lineCount] = v[2][4:0];
               stimSync[lineCount] = v[3][0];
               expI[lineCount]     = v[4][17:0];
               expQ[lineCount]     = v[5][17:0];
               expPhase[lineCount] = v[6][4:0];
               lineCount++;
            end
         end
      end
      $fclose(fd);
      if (lineCount != AccumEnd) begin
         aborted = 1'b1;
         abortReason = "the trace file does not hold the expected number of lines";
      end
   endtask

   task automatic reportTest(input int t);
      if (testErrors[t] == 0) begin
         $display("test %0d %s: ok", t + 1, testNames[t]);
      end else begin
         $display("test %0d %s: %0d errors", t + 1, testNames[t], testErrors[t]);
      end
   endtask

   // ------------------------------------------------------------------------
   // output checks, in trace order
   // ------------------------------------------------------------------------
   task automatic checkOutput;
      int t;
      if (outCount >= lineCount) begin
         assert (0) else begin
            $display("an output arrived after the last trace line");
            errors++;
            testErrors[3]++;
         end
      end else begin
         t = testOf(outCount);
         assert (outSample.iq.i == expI[outCount]) else begin
            $display("CHECK FAILED outSample.iq.i line %0d: got %05h expected %05h",
                     outCount, outSample.iq.i, expI[outCount]);
            errors++;
            testErrors[t]++;
         end
         assert (outSample.iq.q == expQ[outCount]) else begin
            $display("CHECK FAILED outSample.iq.q line %0d: got %05h expected %05h",
                     outCount, outSample.iq.q, expQ[outCount]);
            errors++;
            testErrors[t]++;
         end
         assert (outSample.phase.raw == expPhase[outCount]) else begin
            $display("CHECK FAILED outSample.phase line %0d: got %02h expected %02h",
                     outCount, outSample.phase.raw, expPhase[outCount]);
            errors++;
            testErrors[t]++;
         end
      end
      // full initial grant before the first output
      if (outCount == 0) begin
         assert (creditsIn == QueueDepth) else begin
            $display("CHECK FAILED creditsIn at first output: got %0h expected %0h",
                     creditsIn, QueueDepth);
            errors++;
            testErrors[4]++;
         end
      end
      assert (creditsIn <= QueueDepth + outCount) else begin
         $display("more input credits were granted than queue slots were freed");
         errors++;
         testErrors[4]++;
      end
      assert (outCount < creditsReturned) else begin
         $display("an output left without a returned downstream credit");
         errors++;
         testErrors[3]++;
      end
      outCount++;
      if (outCount == ZeroEnd) reportTest(0);
      if (outCount == PhasesEnd) reportTest(1);
      if (outCount == AccumEnd) reportTest(2);
   endtask

   // random gap of 0 to 7 cycles, one lfsr step per bit
   task automatic drawGap(output int gap);
      logic [2:0] bits;
      bits = '0;
      repeat (3) begin
         lfsr = nextLfsr(lfsr);
         bits = {bits[1:0], lfsr[0]};
      end
      gap = int'(bits);
   endtask

   // ------------------------------------------------------------------------
   // monitor and downstream credit return
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      if (reset) begin
         outCredit = 1'b0;
      end else begin
         if (inCredit) creditsIn++;
         if (outValid) checkOutput();
         if (creditsReturned >= lineCount) begin
            outCredit = 1'b0;
         end else if (gapLeft == 0) begin
            outCredit = 1'b1;
            creditsReturned++;
            drawGap(gapLeft);
         end else begin
            outCredit = 1'b0;
            gapLeft--;
         end
      end
   end

   initial begin
      int waitCycles;
      int lastOut;
      clk = 1'b0;
      reset = 1'b1;
      inValid = 1'b0;
      inSample = '0;
      lfsr = 32'h2bdd;
      gapLeft = 0;
      aborted = 1'b0;
      testNames[0] = "zero phase";
      testNames[1] = "all phases";
      testNames[2] = "accumulation";
      testNames[3] = "ordering under back-pressure";
      testNames[4] = "input credits";
      loadTrace();
      repeat (3) @(posedge clk);
      @(negedge clk) reset <= 1'b0;

      // send only while holding credits
      waitCycles = 0;
      while (!aborted && sentCount < lineCount) begin
         @(negedge clk);
         if (heldCredits > 0) begin
            inValid = 1'b1;
            inSample.iq.i = stimI[sentCount];
            inSample.iq.q = stimQ[sentCount];
            inSample.phaseStep = stimStep[sentCount];
            inSample.sync = stimSync[sentCount];
            heldCredits--;
            sentCount++;
            waitCycles = 0;
         end else begin
            inValid = 1'b0;
            waitCycles++;
            if (waitCycles >= TimeoutCycles) begin
               aborted = 1'b1;
               abortReason = "no input credit arrived within 200 cycles";
            end
         end
         // upstream registers the pulse, spent from the next cycle on
         if (inCredit) heldCredits++;
      end
      @(negedge clk) inValid = 1'b0;

      // drain, timeout restarts on each output
      waitCycles = 0;
      lastOut = outCount;
      while (!aborted && outCount < lineCount) begin
         @(posedge clk);
         if (outCount != lastOut) begin
            lastOut = outCount;
            waitCycles = 0;
         end else begin
            waitCycles++;
            if (waitCycles >= TimeoutCycles) begin
               aborted = 1'b1;
               abortReason = "outputs stopped before the whole trace came out";
            end
         end
      end

      // late grants follow the last outputs
      waitCycles = 0;
      while (!aborted && creditsIn != QueueDepth + outCount) begin
         @(posedge clk);
         waitCycles++;
         if (waitCycles >= TimeoutCycles) begin
            aborted = 1'b1;
            abortReason = "input credits never matched the queue depth plus outputs";
         end
      end

      if (!aborted) begin
         reportTest(3);
         reportTest(4);
      end
      $display("outputs checked %0d of %0d, errors %0d", outCount, lineCount, errors);
      if (aborted) begin
         $display("run aborted: %s", abortReason);
         $display("TEST FAILED");
      end else if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/rotTrace.txt ====
# columns: i q phaseStep sync expectedI expectedQ expectedPhase, all hex
# zero phase, all 32 phases with sync, then accumulation without sync
20000 20000 00 1 20001 20001 00
01234 3ffff 00 1 01234 3ffff 00
20000 05678 00 1 20001 05678 00
10000 00000 00 1 10000 00000 00
10000 00000 01 1 0fb15 031f1 01
10000 00000 02 1 0ec83 061f8 02
10000 00000 03 1 0d4db 08e3a 03
10000 00000 04 1 0b505 0b505 04
10000 00000 05 1 08e3a 0d4db 05
10000 00000 06 1 061f8 0ec83 06
10000 00000 07 1 031f1 0fb15 07
10000 00000 08 1 00000 10000 08
10000 00000 09 1 3ce0f 0fb15 09
10000 00000 0a 1 39e08 0ec83 0a
10000 00000 0b 1 371c6 0d4db 0b
10000 00000 0c 1 34afb 0b505 0c
10000 00000 0d 1 32b25 08e3a 0d
10000 00000 0e 1 3137d 061f8 0e
10000 00000 0f 1 304eb 031f1 0f
10000 00000 10 1 30000 00000 10
10000 00000 11 1 304eb 3ce0f 11
10000 00000 12 1 3137d 39e08 12
10000 00000 13 1 32b25 371c6 13
10000 00000 14 1 34afb 34afb 14
10000 00000 15 1 371c6 32b25 15
10000 00000 16 1 39e08 3137d 16
10000 00000 17 1 3ce0f 304eb 17
10000 00000 18 1 00000 30000 18
10000 00000 19 1 031f1 304eb 19
10000 00000 1a 1 061f8 3137d 1a
10000 00000 1b 1 08e3a 32b25 1b
10000 00000 1c 1 0b505 34afb 1c
10000 00000 1d 1 0d4db 371c6 1d
10000 00000 1e 1 0ec83 39e08 1e
10000 00000 1f 1 0fb15 3ce0f 1f
10000 00000 03 1 0d4db 08e3a 03
10000 00000 05 0 00000 10000 08
10000 00000 07 0 304eb 031f1 0f
10000 00000 0a 0 031f1 304eb 19
10000 00000 09 0 0ec83 061f8 02
10000 00000 1f 0 0fb15 031f1 01
10000 00000 10 0 304eb 3ce0f 11
10000 00000 14 0 08e3a 0d4db 05
10000 00000 00 0 08e3a 0d4db 05
10000 00000 0c 0 304eb 3ce0f 11

// ==== phaseRot.f ====
src/rotPkg.sv
src/phaseAccum.sv
src/rot.sv
src/rotator.sv
src/creditQueue.sv
src/phaseRotTop.sv
tests/phaseRotTop_sva.sv
tests/phaseRotTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= phaseRotTb
FILELIST  ?= phaseRot.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
